/* mem_subsys.f */
design/mem_pkg.sv
design/req_decoder.sv
design/sram_bank.sv
design/resp_arbiter.sv
design/mem_subsys.sv
dv/tb_mem_subsys.sv

/* run.sh */
#!/bin/sh
# build and run the mem_subsys testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_mem_subsys \
  -f mem_subsys.f -Mdir obj_dir -o sim_mem_subsys
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/sim_mem_subsys)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "^TEST OK$"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* dv/mem_patterns.txt */
// test, write flag, word address, write data, byte strobe (all hex)
// reads carry zero data and strobe; test 0 ends the list
2_1_00_11111111_f
2_1_01_22222222_f
2_1_02_33333333_f
2_1_03_44444444_f
2_0_00_00000000_0
2_0_01_00000000_0
2_0_02_00000000_0
2_0_03_00000000_0
2_1_01_a5a5a5a5_f
2_0_01_00000000_0
// partial strobes over full-word base values
3_1_10_aabbccdd_f
3_1_10_11223344_5
3_0_10_00000000_0
3_1_11_deadbeef_f
3_1_11_00000099_1
3_1_11_77000000_8
3_0_11_00000000_0
3_1_10_ffff0000_c
3_0_10_00000000_0
4_1_20_c0de0020_f
4_1_21_c0de0021_f
4_1_22_c0de0022_f
4_1_23_c0de0023_f
4_1_24_c0de0024_f
4_0_20_00000000_0
4_0_21_00000000_0
4_0_22_00000000_0
4_0_23_00000000_0
4_0_24_00000000_0
5_1_30_5a5a0030_f
5_1_31_5a5a0031_f
5_1_32_5a5a0032_f
5_1_33_5a5a0033_f
5_0_30_00000000_0
5_0_31_00000000_0
5_0_32_00000000_0
5_0_33_00000000_0
5_0_10_00000000_0
5_0_11_00000000_0
0_0_00_00000000_0

/* dv/tb_mem_subsys.sv */
module tb_mem_subsys import mem_pkg::*; ();

  localparam int MAX_OPS     = 64;
  localparam int WAIT_LIMIT  = 200;
  localparam int DRAIN_LIMIT = 2000;

  logic  clk = 1'b0;
  logic  rst_i;
  logic  req_valid_i;
  logic  req_write_i;
  addr_t req_addr_i;
  data_t req_wdata_i;
  strb_t req_strb_i;
  id_t   req_id_i;
  logic  rsp_ready_i = 1'b1;
  logic  req_ready_o;
  logic  rsp_valid_o;
  logic  rsp_write_o;
  data_t rsp_rdata_o;
  id_t   rsp_id_o;

  // {test, write, addr, data, strobe}
  logic [51:0] patterns [MAX_OPS];

  // reference memory updated in issue order
  data_t ref_mem [256];
  data_t exp_data [16];
  logic  exp_write [16];
  int    issue_cnt [16];
  int    ret_cnt [16];

  int          issued;
  int          received;
  int          rsp_total;
  int          drv_errs;
  int          mon_errs;
  int          errs_at_start;
  int          tests_passed;
  int          tests_failed;
  id_t         next_id = '0;
  logic        bp_on = 1'b0;
  logic [31:0] rnd_ready = 32'd50;
  logic [31:0] rnd_idle = 32'd50;

  mem_subsys uut (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .req_write_i (req_write_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .req_strb_i  (req_strb_i),
    .req_id_i    (req_id_i),
    .rsp_ready_i (rsp_ready_i),
    .req_ready_o (req_ready_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_write_o (rsp_write_o),
    .rsp_rdata_o (rsp_rdata_o),
    .rsp_id_o    (rsp_id_o)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what, inout int errs);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, actual, expected);
      errs++;
    end
  endtask

  // response side sampled at the falling edge
  always @(negedge clk) begin
    if (bp_on) begin
      rnd_ready = lcg_next(rnd_ready);
      rsp_ready_i = rnd_ready[16];
    end else begin
      rsp_ready_i = 1'b1;
    end
    if (!rst_i && rsp_valid_o && rsp_ready_i) begin
      rsp_total++;
      if (issue_cnt[rsp_id_o] == ret_cnt[rsp_id_o]) begin
        $display("ERROR at %0t: response id %0d was not outstanding", $time, rsp_id_o);
        mon_errs++;
      end else begin
        check_value(32'(rsp_write_o), 32'(exp_write[rsp_id_o]), "rsp_write_o", mon_errs);
        check_value(rsp_rdata_o, exp_data[rsp_id_o], "rsp_rdata_o", mon_errs);
        ret_cnt[rsp_id_o]++;
        received++;
      end
    end
  end

  task automatic issue_op(input logic [51:0] op);
    int    waited;
    addr_t addr;
    data_t wdata;
    strb_t strb;
    data_t mask;
    waited = 0;
    addr   = op[43:36];
    wdata  = op[35:4];
    strb   = op[3:0];
    // an id is reused only after its response came back
    while (issue_cnt[next_id] != ret_cnt[next_id] && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (issue_cnt[next_id] != ret_cnt[next_id]) begin
      $display("timeout: id %0d never came back, request to %h not sent", next_id, addr);
      drv_errs++;
      return;
    end
    req_valid_i = 1'b1;
    req_write_i = op[44];
    req_addr_i  = addr;
    req_wdata_i = wdata;
    req_strb_i  = strb;
    req_id_i    = next_id;
    waited = 0;
    while (!req_ready_o && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!req_ready_o) begin
      $display("timeout: request to address %h was never accepted", addr);
      drv_errs++;
      req_valid_i = 1'b0;
      return;
    end
    // taken at the next rising edge
    if (op[44]) begin
      // strobe bit n enables byte lane n
      mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
      ref_mem[addr] = (ref_mem[addr] & ~mask) | (wdata & mask);
      exp_data[next_id]  = '0;
      exp_write[next_id] = 1'b1;
    end else begin
      exp_data[next_id]  = ref_mem[addr];
      exp_write[next_id] = 1'b0;
    end
    issue_cnt[next_id]++;
    issued++;
    next_id++;
    @(negedge clk);
    req_valid_i = 1'b0;
  endtask

  task automatic drain_all();
    int waited;
    waited = 0;
    while (received != issued && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (received != issued) begin
      $display("timeout: %0d responses still missing at the end of the drain",
               issued - received);
      drv_errs++;
    end
    check_value(32'(rsp_total), 32'(issued), "response count", drv_errs);
  endtask

  task automatic finish_test(input int num, input int ops);
    int errs;
    errs = drv_errs + mon_errs - errs_at_start;
    if (errs == 0) begin
      $display("test %0d passed, %0d operations", num, ops);
      tests_passed++;
    end else begin
      $display("test %0d failed with %0d errors", num, errs);
      tests_failed++;
    end
  endtask

  initial begin
    int         n;
    int         ops;
    logic [3:0] cur;
    rst_i       = 1'b1;
    req_valid_i = 1'b0;
    req_write_i = 1'b0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    req_strb_i  = '0;
    req_id_i    = '0;
    for (int i = 0; i < MAX_OPS; i++) begin
      patterns[i] = '0;
    end
    $readmemh("dv/mem_patterns.txt", patterns);

    // test 1 covers reset
    errs_at_start = 0;
    for (int c = 0; c < 4; c++) begin
      @(negedge clk);
      check_value(32'(rsp_valid_o), 32'd0, "rsp_valid_o in reset", drv_errs);
    end
    rst_i = 1'b0;
    for (int c = 0; c < 3; c++) begin
      @(negedge clk);
      check_value(32'(rsp_valid_o), 32'd0, "rsp_valid_o after reset", drv_errs);
      check_value(32'(req_ready_o), 32'd1, "req_ready_o after reset", drv_errs);
    end
    finish_test(1, 0);

    n = 0;
    while (n < MAX_OPS && patterns[n][51:48] != 4'h0) begin
      cur           = patterns[n][51:48];
      ops           = 0;
      errs_at_start = drv_errs + mon_errs;
      // random stalls on both sides only in test 5
      bp_on = (cur == 4'h5);
      while (n < MAX_OPS && patterns[n][51:48] == cur) begin
        if (bp_on) begin
          rnd_idle = lcg_next(rnd_idle);
          if (rnd_idle[23:22] == 2'b00) begin
            @(negedge clk);
          end
        end
        issue_op(patterns[n]);
        n++;
        ops++;
      end
      drain_all();
      bp_on = 1'b0;
      finish_test(int'(cur), ops);
    end

    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && drv_errs + mon_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* design/mem_subsys.sv */
module mem_subsys import mem_pkg::*; (
  input  logic  clk,
  input  logic  rst_i,
  input  logic  req_valid_i,
  input  logic  req_write_i,
  input  addr_t req_addr_i,
  input  data_t req_wdata_i,
  input  strb_t req_strb_i,
  input  id_t   req_id_i,
  input  logic  rsp_ready_i,
  output logic  req_ready_o,
  output logic  rsp_valid_o,
  output logic  rsp_write_o,
  output data_t rsp_rdata_o,
  output id_t   rsp_id_o
);

  logic [NUM_BANKS-1:0] bank_req_valid;
  logic [NUM_BANKS-1:0] bank_req_ready;
  logic                 bank_req_write;
  idx_t                 bank_req_idx;
  data_t                bank_req_wdata;
  strb_t                bank_req_strb;
  id_t                  bank_req_id;

  logic [NUM_BANKS-1:0] bank_rsp_valid;
  logic [NUM_BANKS-1:0] bank_rsp_ready;
  logic [NUM_BANKS-1:0] bank_rsp_write;
  data_t                bank_rsp_rdata [NUM_BANKS];
  id_t                  bank_rsp_id [NUM_BANKS];

  req_decoder u_decoder (
    .clk          (clk),
    .rst_i        (rst_i),
    .req_valid_i  (req_valid_i),
    .req_write_i  (req_write_i),
    .req_addr_i   (req_addr_i),
    .req_wdata_i  (req_wdata_i),
    .req_strb_i   (req_strb_i),
    .req_id_i     (req_id_i),
    .bank_ready_i (bank_req_ready),
    .req_ready_o  (req_ready_o),
    .bank_valid_o (bank_req_valid),
    .bank_write_o (bank_req_write),
    .bank_idx_o   (bank_req_idx),
    .bank_wdata_o (bank_req_wdata),
    .bank_strb_o  (bank_req_strb),
    .bank_id_o    (bank_req_id)
  );

  // distinct seeds so the banks stall independently
  for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
    sram_bank #(
      .LFSR_SEED (20'd101 + 20'(g) * 20'd7919)
    ) u_bank (
      .clk         (clk),
      .rst_i       (rst_i),
      .req_valid_i (bank_req_valid[g]),
      .req_write_i (bank_req_write),
      .req_idx_i   (bank_req_idx),
      .req_wdata_i (bank_req_wdata),
      .req_strb_i  (bank_req_strb),
      .req_id_i    (bank_req_id),
      .rsp_ready_i (bank_rsp_ready[g]),
      .req_ready_o (bank_req_ready[g]),
      .rsp_valid_o (bank_rsp_valid[g]),
      .rsp_write_o (bank_rsp_write[g]),
      .rsp_rdata_o (bank_rsp_rdata[g]),
      .rsp_id_o    (bank_rsp_id[g])
    );
  end

  resp_arbiter u_arbiter (
    .clk          (clk),
    .rst_i        (rst_i),
    .bank_valid_i (bank_rsp_valid),
    .bank_write_i (bank_rsp_write),
    .bank_rdata_i (bank_rsp_rdata),
    .bank_id_i    (bank_rsp_id),
    .rsp_ready_i  (rsp_ready_i),
    .bank_ready_o (bank_rsp_ready),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_write_o  (rsp_write_o),
    .rsp_rdata_o  (rsp_rdata_o),
    .rsp_id_o     (rsp_id_o)
  );

endmodule

/* design/resp_arbiter.sv */
module resp_arbiter import mem_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_i,
  input  logic [NUM_BANKS-1:0] bank_valid_i,
  input  logic [NUM_BANKS-1:0] bank_write_i,
  input  data_t                bank_rdata_i [NUM_BANKS],
  input  id_t                  bank_id_i [NUM_BANKS],
  input  logic                 rsp_ready_i,
  output logic [NUM_BANKS-1:0] bank_ready_o,
  output logic                 rsp_valid_o,
  output logic                 rsp_write_o,
  output data_t                rsp_rdata_o,
  output id_t                  rsp_id_o
);

  bank_sel_t ptr_q;
  logic      out_valid_q;
  logic      out_write_q;
  data_t     out_rdata_q;
  id_t       out_id_q;

  bank_sel_t cand;
  bank_sel_t gnt_idx;
  logic      gnt_found;
  logic      can_load;

  // empty, or draining this cycle
  assign can_load = !out_valid_q || rsp_ready_i;

  // first valid bank at or after the pointer
  always_comb begin
    gnt_found = 1'b0;
    gnt_idx   = ptr_q;
    cand      = ptr_q;
    for (int i = 0; i < NUM_BANKS; i++) begin
      cand = ptr_q + bank_sel_t'(i);
      if (!gnt_found && bank_valid_i[cand]) begin
        gnt_found = 1'b1;
        gnt_idx   = cand;
      end
    end
  end

  always_comb begin
    bank_ready_o = '0;
    if (gnt_found && can_load) begin
      bank_ready_o[gnt_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      out_valid_q <= 1'b0;
      ptr_q       <= '0;
    end else if (can_load) begin
      out_valid_q <= gnt_found;
      if (gnt_found) begin
        ptr_q <= gnt_idx + bank_sel_t'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (can_load && gnt_found) begin
      out_write_q <= bank_write_i[gnt_idx];
      out_rdata_q <= bank_rdata_i[gnt_idx];
      out_id_q    <= bank_id_i[gnt_idx];
    end
  end

  assign rsp_valid_o = out_valid_q;
  assign rsp_write_o = out_write_q;
  assign rsp_rdata_o = out_rdata_q;
  assign rsp_id_o    = out_id_q;

endmodule

/* design/sram_bank.sv */
module sram_bank import mem_pkg::*; #(
  parameter logic [19:0] LFSR_SEED = 20'd101
) (
  input  logic  clk,
  input  logic  rst_i,
  input  logic  req_valid_i,
  input  logic  req_write_i,
  input  idx_t  req_idx_i,
  input  data_t req_wdata_i,
  input  strb_t req_strb_i,
  input  id_t   req_id_i,
  input  logic  rsp_ready_i,
  output logic  req_ready_o,
  output logic  rsp_valid_o,
  output logic  rsp_write_o,
  output data_t rsp_rdata_o,
  output id_t   rsp_id_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACCESS,
    ST_RESP
  } state_e;

  state_e state_q;

  data_t mem [BANK_WORDS];

  logic  write_q;
  idx_t  idx_q;
  data_t wdata_q;
  strb_t strb_q;
  id_t   id_q;
  data_t rdata_q;

  logic [19:0] lfsr_q;
  logic        lfsr_go;
  logic        req_fire;
  logic        access_step;

  // x^20 + x^17 + 1, maximal length
  always_ff @(posedge clk) begin
    if (rst_i) begin
      lfsr_q <= LFSR_SEED;
    end else begin
      lfsr_q <= {lfsr_q[18:0], lfsr_q[19] ^ lfsr_q[16]};
    end
  end

  assign lfsr_go     = lfsr_q[19];
  assign req_ready_o = (state_q == ST_IDLE);
  assign req_fire    = req_valid_i && req_ready_o;
  assign access_step = (state_q == ST_ACCESS) && lfsr_go;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (req_fire) begin
            state_q <= ST_ACCESS;
          end
        end
        ST_ACCESS: begin
          // random wait until the tap allows the step
          if (lfsr_go) begin
            state_q <= ST_RESP;
          end
        end
        ST_RESP: begin
          if (rsp_ready_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // latch the accepted request
  always_ff @(posedge clk) begin
    if (req_fire) begin
      write_q <= req_write_i;
      idx_q   <= req_idx_i;
      wdata_q <= req_wdata_i;
      strb_q  <= req_strb_i;
      id_q    <= req_id_i;
    end
  end

  // array access, byte lanes gated by strobe
  always_ff @(posedge clk) begin
    if (access_step) begin
      if (write_q) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (strb_q[b]) begin
            mem[idx_q][8*b +: 8] <= wdata_q[8*b +: 8];
          end
        end
        rdata_q <= '0;
      end else begin
        rdata_q <= mem[idx_q];
      end
    end
  end

  assign rsp_valid_o = (state_q == ST_RESP);
  assign rsp_write_o = write_q;
  assign rsp_rdata_o = rdata_q;
  assign rsp_id_o    = id_q;

endmodule

/* design/req_decoder.sv */
module req_decoder import mem_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_i,
  input  logic                 req_valid_i,
  input  logic                 req_write_i,
  input  addr_t                req_addr_i,
  input  data_t                req_wdata_i,
  input  strb_t                req_strb_i,
  input  id_t                  req_id_i,
  input  logic [NUM_BANKS-1:0] bank_ready_i,
  output logic                 req_ready_o,
  output logic [NUM_BANKS-1:0] bank_valid_o,
  output logic                 bank_write_o,
  output idx_t                 bank_idx_o,
  output data_t                bank_wdata_o,
  output strb_t                bank_strb_o,
  output id_t                  bank_id_o
);

  logic      full_q;
  bank_sel_t sel_q;
  logic      write_q;
  idx_t      idx_q;
  data_t     wdata_q;
  strb_t     strb_q;
  id_t       id_q;

  logic req_fire;
  logic bank_fire;

  // held request leaves when its bank takes it
  assign bank_fire   = full_q && bank_ready_i[sel_q];
  assign req_ready_o = !full_q || bank_ready_i[sel_q];
  assign req_fire    = req_valid_i && req_ready_o;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (req_fire) begin
      full_q <= 1'b1;
    end else if (bank_fire) begin
      full_q <= 1'b0;
    end
  end

  // low address bits pick the bank
  always_ff @(posedge clk) begin
    if (req_fire) begin
      sel_q   <= req_addr_i[BANK_SEL_W-1:0];
      idx_q   <= req_addr_i[ADDR_W-1:BANK_SEL_W];
      write_q <= req_write_i;
      wdata_q <= req_wdata_i;
      strb_q  <= req_strb_i;
      id_q    <= req_id_i;
    end
  end

  always_comb begin
    bank_valid_o = '0;
    if (full_q) begin
      bank_valid_o[sel_q] = 1'b1;
    end
  end

  assign bank_write_o = write_q;
  assign bank_idx_o   = idx_q;
  assign bank_wdata_o = wdata_q;
  assign bank_strb_o  = strb_q;
  assign bank_id_o    = id_q;

endmodule

/* design/mem_pkg.sv */
package mem_pkg;

  // bank layout
  localparam int NUM_BANKS  = 4;
  localparam int BANK_SEL_W = 2;
  localparam int BANK_WORDS = 64;
  localparam int IDX_W      = 6;

  // word address is {index, bank}
  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;
  localparam int STRB_W = 4;
  localparam int ID_W   = 4;

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [STRB_W-1:0]     strb_t;
  typedef logic [ID_W-1:0]       id_t;
  typedef logic [BANK_SEL_W-1:0] bank_sel_t;
  typedef logic [IDX_W-1:0]      idx_t;

endpackage
